//--- neuron_pkg.sv
/*
 * shared definitions for the neuron-side network interface
 *   flit and packet field sizes, spike vector size
 *   node coordinates and flit FIFO sizing
 *   flit_t, packet_t and spike_vec_t types
 */
package neuron_pkg;

    // flit and packet framing
    localparam int FLIT_W           = 4;
    localparam int FLITS_PER_PACKET = 8;
    localparam int PACKET_W         = FLIT_W * FLITS_PER_PACKET;
    localparam int FLIT_CNT_W       = $clog2(FLITS_PER_PACKET);

    // packet fields, x at bit 0, then y, then axon
    localparam int X_ADDR_W  = 8;
    localparam int Y_ADDR_W  = 8;
    localparam int AXON_ID_W = 4;
    localparam int AXON_LSB  = X_ADDR_W + Y_ADDR_W;
    localparam int NUM_AXONS = 1 << AXON_ID_W;

    // coordinates of this node in the mesh
    localparam int LOCAL_X = 1;
    localparam int LOCAL_Y = 1;

    // inbound packet storage
    localparam int FIFO_DEPTH_PACKETS = 4;
    localparam int FIFO_ADDR_W        = $clog2(FIFO_DEPTH_PACKETS);
    localparam int FIFO_PTR_W         = FIFO_ADDR_W + 1;

    typedef logic [FLIT_W-1:0]    flit_t;
    typedef logic [PACKET_W-1:0]  packet_t;
    typedef logic [NUM_AXONS-1:0] spike_vec_t;

endpackage

//--- flit_async_fifo.sv
/*
 * dual-clock inbound FIFO
 *   router_clk side packs eight flits into one packet
 *   packet memory indexed by binary pointers
 *   gray pointers crossed through two-flop synchronisers
 *   neuron_clk side presents the head packet with rx_valid
 */
`timescale 1ns/100ps

module flit_async_fifo (
    input  logic                router_clk,
    input  logic                neuron_clk,
    input  logic                rst_n,
    input  neuron_pkg::flit_t   flit_in,
    input  logic                flit_valid,
    output logic                flit_ready,
    output neuron_pkg::packet_t rx_packet,
    output logic                rx_valid,
    input  logic                rx_ready
);
    import neuron_pkg::*;

    function automatic logic [FIFO_PTR_W-1:0] bin2gray(input logic [FIFO_PTR_W-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // packet storage, written in router_clk and read in neuron_clk
    packet_t mem [FIFO_DEPTH_PACKETS];

    // write side
    logic [PACKET_W-FLIT_W-1:0] flit_shreg;
    logic [FLIT_CNT_W-1:0]      flit_cnt;
    logic [FIFO_PTR_W-1:0]      wbin;
    logic [FIFO_PTR_W-1:0]      wbin_next;
    logic [FIFO_PTR_W-1:0]      wgray;
    logic [FIFO_PTR_W-1:0]      rgray_w1;
    logic [FIFO_PTR_W-1:0]      rgray_w2;
    packet_t                    pkt_next;
    logic                       wfull;
    logic                       flit_fire;
    logic                       last_flit;

    // read side
    logic [FIFO_PTR_W-1:0]      rbin;
    logic [FIFO_PTR_W-1:0]      rbin_next;
    logic [FIFO_PTR_W-1:0]      rgray;
    logic [FIFO_PTR_W-1:0]      wgray_r1;
    logic [FIFO_PTR_W-1:0]      wgray_r2;
    logic                       rempty;
    logic                       rd_fire;

    // newest flit lands on top, so the first flit ends up in bits 0 to 3
    assign pkt_next  = {flit_in, flit_shreg};
    assign flit_fire = flit_valid & flit_ready;
    assign last_flit = flit_fire && (flit_cnt == FLIT_CNT_W'(FLITS_PER_PACKET - 1));
    assign wbin_next = wbin + 1'b1;

    // full when the write pointer has lapped the synchronised read pointer
    assign wfull = (wgray == {~rgray_w2[FIFO_PTR_W-1:FIFO_PTR_W-2],
                              rgray_w2[FIFO_PTR_W-3:0]});
    assign flit_ready = ~wfull;

    always_ff @(posedge router_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            flit_cnt <= '0;
            wbin     <= '0;
            wgray    <= '0;
        end
        else if (flit_fire)
        begin
            flit_cnt <= last_flit ? '0 : flit_cnt + 1'b1;
            if (last_flit)
            begin
                wbin  <= wbin_next;
                wgray <= bin2gray(wbin_next);
            end
        end
    end

    always_ff @(posedge router_clk)
    begin
        if (flit_fire)
            flit_shreg <= pkt_next[PACKET_W-1:FLIT_W];
        if (last_flit)
            mem[wbin[FIFO_ADDR_W-1:0]] <= pkt_next;
    end

    // read pointer into the router_clk domain
    always_ff @(posedge router_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end
        else
        begin
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
        end
    end

    // write pointer into the neuron_clk domain
    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end
        else
        begin
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
        end
    end

    assign rempty    = (rgray == wgray_r2);
    assign rx_valid  = ~rempty;
    assign rx_packet = mem[rbin[FIFO_ADDR_W-1:0]];
    assign rd_fire   = rx_valid & rx_ready;
    assign rbin_next = rbin + 1'b1;

    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rbin  <= '0;
            rgray <= '0;
        end
        else if (rd_fire)
        begin
            rbin  <= rbin_next;
            rgray <= bin2gray(rbin_next);
        end
    end

endmodule

//--- packet_arbiter.sv
/*
 * packet arbiter between the local neuron core and the inbound FIFO
 *   local packets win over remote packets
 *   local coordinate match keeps the packet as a spike
 *   other local packets go out through the egress stage
 *   registered set_en and axon_id toward the spike accumulator
 */
`timescale 1ns/100ps

module packet_arbiter (
    input  logic                            neuron_clk,
    input  logic                            rst_n,
    input  neuron_pkg::packet_t             local_packet,
    input  logic                            local_valid,
    output logic                            local_ready,
    input  neuron_pkg::packet_t             rx_packet,
    input  logic                            rx_valid,
    output logic                            rx_ready,
    output logic                            set_en,
    output logic [neuron_pkg::AXON_ID_W-1:0] axon_id,
    output neuron_pkg::packet_t             eg_packet,
    output logic                            eg_valid,
    input  logic                            eg_ready
);
    import neuron_pkg::*;

    logic [X_ADDR_W-1:0]  local_x;
    logic [Y_ADDR_W-1:0]  local_y;
    logic                 local_hit;
    logic                 local_spike;
    logic                 remote_spike;
    logic [AXON_ID_W-1:0] axon_sel;

    // coordinate fields of the local packet
    assign local_x = local_packet[X_ADDR_W-1:0];
    assign local_y = local_packet[X_ADDR_W +: Y_ADDR_W];

    assign local_hit = (local_x == X_ADDR_W'(LOCAL_X)) && (local_y == Y_ADDR_W'(LOCAL_Y));

    // a hit always goes into the spike vector, a miss waits for the egress stage
    assign local_ready = local_hit | eg_ready;

    // remote packets only drain while the neuron core is quiet
    assign rx_ready = ~local_valid;

    // non-local packets pass through untouched
    assign eg_packet = local_packet;
    assign eg_valid  = local_valid & ~local_hit;

    assign local_spike  = local_valid & local_hit;
    assign remote_spike = rx_valid & rx_ready;

    assign axon_sel = local_valid ? local_packet[AXON_LSB +: AXON_ID_W]
                                  : rx_packet[AXON_LSB +: AXON_ID_W];

    // one set pulse per accepted spike
    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
            set_en <= 1'b0;
        else
            set_en <= local_spike | remote_spike;
    end

    // axon index travels alongside set_en
    always_ff @(posedge neuron_clk)
    begin
        if (local_spike | remote_spike)
            axon_id <= axon_sel;
    end

endmodule

//--- spike_accumulator.sv
/*
 * axon-indexed spike register
 *   start is registered into a clear flag
 *   clear zeroes the vector and wins over a set
 *   set_en marks the bit selected by axon_id
 */
`timescale 1ns/100ps

module spike_accumulator (
    input  logic                            neuron_clk,
    input  logic                            rst_n,
    input  logic                            start,
    input  logic                            set_en,
    input  logic [neuron_pkg::AXON_ID_W-1:0] axon_id,
    output neuron_pkg::spike_vec_t          spike
);
    import neuron_pkg::*;

    logic clear_q;

    // start arrives as a one-cycle pulse
    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
            clear_q <= 1'b0;
        else
            clear_q <= start;
    end

    // bits stay set until the next time step begins
    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
            spike <= '0;
        else if (clear_q)
            spike <= '0;
        else if (set_en)
            spike[axon_id] <= 1'b1;
    end

endmodule

//--- router_egress.sv
/*
 * outbound skid buffer toward the router
 *   output register plus one skid entry
 *   eg_ready is low while the skid entry is occupied
 *   packets leave in order and hold under back-pressure
 */
`timescale 1ns/100ps

module router_egress (
    input  logic                neuron_clk,
    input  logic                rst_n,
    input  neuron_pkg::packet_t eg_packet,
    input  logic                eg_valid,
    output logic                eg_ready,
    output neuron_pkg::packet_t out_packet,
    output logic                out_valid,
    input  logic                out_ready
);
    import neuron_pkg::*;

    packet_t skid_packet;
    logic    skid_full;
    logic    eg_fire;
    logic    out_free;

    // ready comes straight from the skid flop
    assign eg_ready = ~skid_full;
    assign eg_fire  = eg_valid & eg_ready;
    assign out_free = out_ready | ~out_valid;

    always_ff @(posedge neuron_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            skid_full <= 1'b0;
        end
        else if (out_free)
        begin
            // skid entry is older, so it moves first
            out_valid <= skid_full | eg_fire;
            skid_full <= 1'b0;
        end
        else if (eg_fire)
            skid_full <= 1'b1;
    end

    always_ff @(posedge neuron_clk)
    begin
        if (out_free && skid_full)
            out_packet <= skid_packet;
        else if (out_free && eg_fire)
            out_packet <= eg_packet;

        if (!out_free && eg_fire)
            skid_packet <= eg_packet;
    end

endmodule

//--- spike_interface_top.sv
/*
 * neuron-side network interface top level
 *   inbound flit FIFO across router_clk and neuron_clk
 *   packet arbiter with local bypass
 *   spike accumulator and outbound skid buffer
 */
`timescale 1ns/100ps

module spike_interface_top (
    input  logic                   router_clk,
    input  logic                   neuron_clk,
    input  logic                   rst_n,
    input  neuron_pkg::flit_t      flit_in,
    input  logic                   flit_valid,
    output logic                   flit_ready,
    input  neuron_pkg::packet_t    local_packet,
    input  logic                   local_valid,
    output logic                   local_ready,
    output neuron_pkg::packet_t    out_packet,
    output logic                   out_valid,
    input  logic                   out_ready,
    input  logic                   start,
    output neuron_pkg::spike_vec_t spike
);
    import neuron_pkg::*;

    // FIFO to arbiter
    packet_t              rx_packet;
    logic                 rx_valid;
    logic                 rx_ready;

    // arbiter to accumulator
    logic                 set_en;
    logic [AXON_ID_W-1:0] axon_id;

    // arbiter to egress
    packet_t              eg_packet;
    logic                 eg_valid;
    logic                 eg_ready;

    flit_async_fifo fifo0 (
        .router_clk (router_clk),
        .neuron_clk (neuron_clk),
        .rst_n      (rst_n),
        .flit_in    (flit_in),
        .flit_valid (flit_valid),
        .flit_ready (flit_ready),
        .rx_packet  (rx_packet),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready)
    );

    packet_arbiter arb0 (
        .neuron_clk   (neuron_clk),
        .rst_n        (rst_n),
        .local_packet (local_packet),
        .local_valid  (local_valid),
        .local_ready  (local_ready),
        .rx_packet    (rx_packet),
        .rx_valid     (rx_valid),
        .rx_ready     (rx_ready),
        .set_en       (set_en),
        .axon_id      (axon_id),
        .eg_packet    (eg_packet),
        .eg_valid     (eg_valid),
        .eg_ready     (eg_ready)
    );

    spike_accumulator acc0 (
        .neuron_clk (neuron_clk),
        .rst_n      (rst_n),
        .start      (start),
        .set_en     (set_en),
        .axon_id    (axon_id),
        .spike      (spike)
    );

    router_egress egress0 (
        .neuron_clk (neuron_clk),
        .rst_n      (rst_n),
        .eg_packet  (eg_packet),
        .eg_valid   (eg_valid),
        .eg_ready   (eg_ready),
        .out_packet (out_packet),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

//--- tb_clock_gen.sv
/*
 * free-running testbench clock
 *   period set by parameter, even duty cycle
 */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

//--- spike_interface_asserts.sv
/*
 * concurrent checks bound into spike_interface_top
 *   outbound and local handshakes hold under back-pressure
 *   spike vector zero after start, out_valid low in reset
 */
`timescale 1ns/100ps

module spike_interface_asserts (
    input logic                   neuron_clk,
    input logic                   rst_n,
    input neuron_pkg::packet_t    local_packet,
    input logic                   local_valid,
    input logic                   local_ready,
    input neuron_pkg::packet_t    out_packet,
    input logic                   out_valid,
    input logic                   out_ready,
    input logic                   start,
    input neuron_pkg::spike_vec_t spike
);

    out_hold: assert property (@(posedge neuron_clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_packet))
        else $error("outbound packet changed while out_ready was low");

    local_hold: assert property (@(posedge neuron_clk) disable iff (!rst_n)
        local_valid && !local_ready |=> local_valid && $stable(local_packet))
        else $error("local packet changed while local_ready was low");

    // start passes through the clear flag, so the vector is zero from the second edge
    start_clear: assert property (@(posedge neuron_clk) disable iff (!rst_n)
        start |-> ##2 (spike == '0))
        else $error("spike vector not cleared after start");

    reset_quiet: assert property (@(posedge neuron_clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind spike_interface_top spike_interface_asserts asserts0 (.*);

//--- spike_interface_tb.sv
/*
 * testbench for the neuron-side network interface
 *   stimulus table of remote and local packets applied in a loop
 *   reference spike vector and outbound packet queue
 *   back-pressure run that fills the flit FIFO
 */
`timescale 1ns/100ps

module spike_interface_tb;
    import neuron_pkg::*;

    localparam int WAIT_LIMIT = 1000;

    typedef struct packed {
        logic       remote;
        logic       clear_first;
        logic [7:0] x;
        logic [7:0] y;
        logic [3:0] axon;
        logic       to_spike;
    } row_t;

    logic       neuron_clk, router_clk, rst_n, start;
    logic       flit_valid, flit_ready, local_valid, local_ready, out_valid, out_ready;
    flit_t      flit_in;
    packet_t    local_packet, out_packet, pkt;
    spike_vec_t spike, exp_spike;
    packet_t    out_q[$];
    row_t       rows[$];
    // 0 keeps out_ready low, 1 keeps it high, 2 toggles it at random
    int         out_mode;
    int         error_count;

    tb_clock_gen #(.PERIOD_NS(100)) neuron_clk_gen (.clk(neuron_clk));
    tb_clock_gen #(.PERIOD_NS(70))  router_clk_gen (.clk(router_clk));

    spike_interface_top dut0 (.*);

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string name);
        if (actual !== expected)
        begin
            error_count++;
            $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // eight flits, lowest nibble first, with random idle cycles after each
    task automatic send_flits(input packet_t pkt_in);
        int cycles;
        @(posedge router_clk);
        #10;
        for (int i = 0; i < FLITS_PER_PACKET; i++)
        begin
            flit_in    = pkt_in[i*FLIT_W +: FLIT_W];
            flit_valid = 1'b1;
            @(negedge router_clk);
            for (cycles = 0; !flit_ready; cycles++)
            begin
                if (cycles == WAIT_LIMIT)
                    timed_out("flit_ready");
                @(negedge router_clk);
            end
            @(posedge router_clk);
            #10;
            flit_valid = 1'b0;
            repeat ($urandom % 3)
            begin
                @(posedge router_clk);
                #10;
            end
        end
    endtask

    task automatic send_local(input packet_t pkt_in);
        int cycles;
        @(posedge neuron_clk);
        #10;
        local_packet = pkt_in;
        local_valid  = 1'b1;
        @(negedge neuron_clk);
        for (cycles = 0; !local_ready; cycles++)
        begin
            if (cycles == WAIT_LIMIT)
                timed_out("local_ready");
            @(negedge neuron_clk);
        end
        @(posedge neuron_clk);
        #10;
        local_valid = 1'b0;
    endtask

    task automatic wait_spike();
        int cycles;
        @(negedge neuron_clk);
        for (cycles = 0; spike !== exp_spike; cycles++)
        begin
            if (cycles == WAIT_LIMIT)
                check_value(spike, exp_spike, "spike");
            @(negedge neuron_clk);
        end
    endtask

    task automatic wait_drained();
        int cycles;
        @(negedge neuron_clk);
        for (cycles = 0; out_q.size() != 0 || out_valid; cycles++)
        begin
            if (cycles == WAIT_LIMIT)
                timed_out("the outbound packets to drain");
            @(negedge neuron_clk);
        end
    endtask

    // out_ready follows out_mode, a little after each rising edge
    initial
    begin
        out_ready = 1'b0;
        forever
        begin
            @(posedge neuron_clk);
            #10;
            out_ready = (out_mode == 2) ? 1'($urandom % 2) : (out_mode == 1);
        end
    end

    // each outbound transfer must match the oldest expected packet
    always @(negedge neuron_clk)
    begin
        if (rst_n && out_valid && out_ready)
        begin
            if (out_q.size() == 0)
            begin
                $display("packet %h left on out_packet but none was expected", out_packet);
                abort_run();
            end
            else
                check_value(out_packet, out_q.pop_front(), "out_packet");
        end
    end

    initial
    begin
        int seed_draw;
        int cycles;
        seed_draw    = $urandom(32'h8044);
        error_count  = 0;
        out_mode     = 1;
        exp_spike    = '0;
        flit_in      = '0;
        flit_valid   = 1'b0;
        local_packet = '0;
        local_valid  = 1'b0;
        start        = 1'b0;
        rst_n        = 1'b1;
        #1;
        rst_n = 1'b0;
        repeat (10) @(posedge neuron_clk);
        #10;
        rst_n = 1'b1;
        @(negedge neuron_clk);
        check_value(spike, '0, "spike");
        check_value(out_valid, 1'b0, "out_valid");
        check_value(flit_ready, 1'b1, "flit_ready");

        // remote, start first, x, y, axon, expected spike (1) or outbound packet (0)
        rows.push_back({1'b1, 1'b0, 8'd3, 8'd2, 4'd5,  1'b1});
        rows.push_back({1'b1, 1'b0, 8'd0, 8'd7, 4'd0,  1'b1});
        rows.push_back({1'b1, 1'b0, 8'd1, 8'd1, 4'd15, 1'b1});
        rows.push_back({1'b0, 1'b0, 8'd1, 8'd1, 4'd7,  1'b1});
        rows.push_back({1'b0, 1'b0, 8'd2, 8'd1, 4'd3,  1'b0});
        rows.push_back({1'b0, 1'b0, 8'd0, 8'd0, 4'd9,  1'b0});
        rows.push_back({1'b0, 1'b0, 8'd1, 8'd4, 4'd1,  1'b0});
        rows.push_back({1'b0, 1'b0, 8'd7, 8'd1, 4'd2,  1'b0});
        rows.push_back({1'b1, 1'b1, 8'd4, 8'd4, 4'd5,  1'b1});
        rows.push_back({1'b0, 1'b0, 8'd1, 8'd1, 4'd12, 1'b1});
        rows.push_back({1'b0, 1'b0, 8'd9, 8'd9, 4'd4,  1'b0});

        out_mode = 2;
        foreach (rows[i])
        begin
            if (rows[i].clear_first)
            begin
                @(posedge neuron_clk);
                #10;
                start = 1'b1;
                @(posedge neuron_clk);
                #10;
                start     = 1'b0;
                exp_spike = '0;
                // start is registered once before the vector clears
                @(posedge neuron_clk);
                @(negedge neuron_clk);
                check_value(spike, exp_spike, "spike");
            end
            pkt = {12'($urandom), rows[i].axon, rows[i].y, rows[i].x};
            if (rows[i].to_spike)
                exp_spike[rows[i].axon] = 1'b1;
            else
                out_q.push_back(pkt);
            if (rows[i].remote)
                send_flits(pkt);
            else
                send_local(pkt);
            if (rows[i].to_spike)
                wait_spike();
        end
        wait_drained();

        // two misses fill the egress stage, the third one stalls the arbiter
        out_mode = 0;
        repeat (2) @(posedge neuron_clk);
        for (int n = 0; n < 3; n++)
        begin
            pkt = {12'($urandom), 4'(n), 8'd6, 8'd5};
            out_q.push_back(pkt);
            if (n < 2)
                send_local(pkt);
        end
        fork
            send_local(pkt);
            begin
                for (int n = 0; n < FIFO_DEPTH_PACKETS; n++)
                begin
                    exp_spike[8 + n] = 1'b1;
                    send_flits({12'($urandom), 4'(8 + n), 8'd2, 8'd2});
                end
                @(negedge router_clk);
                for (cycles = 0; flit_ready; cycles++)
                begin
                    if (cycles == WAIT_LIMIT)
                        timed_out("flit_ready to drop with the flit FIFO full");
                    @(negedge router_clk);
                end
                check_value(local_ready, 1'b0, "local_ready");
                out_mode      = 1;
                exp_spike[13] = 1'b1;
                send_flits({12'($urandom), 4'd13, 8'd2, 8'd2});
            end
        join
        wait_drained();
        wait_spike();

        if (error_count == 0)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
            abort_run();
    end

endmodule

//--- sources.f
neuron_pkg.sv
flit_async_fifo.sv
packet_arbiter.sv
spike_accumulator.sv
router_egress.sv
spike_interface_top.sv
tb_clock_gen.sv
spike_interface_asserts.sv
spike_interface_tb.sv
